/* hdl/tea_pkg.sv */
// Types, function codes and cipher constants for the TEA accelerator, imported by its RTL modules
`default_nettype none

package tea_pkg;

	////////////////////
	// Data types

	// One CPU data word
	typedef logic [31:0] word_t;

	// 64-bit cipher block, v0 is the lower word
	typedef struct packed
	{
		word_t v1;
		word_t v0;
	} block_t;

	// Function identifier of a custom instruction
	typedef logic [9:0] func_id_t;

	// Command as presented by the CPU
	typedef struct packed
	{
		func_id_t function_id;
		word_t    inputs_0;
		word_t    inputs_1;
	} tea_cmd_t;

	////////////////////
	// Function codes

	// Only bits [1:0] are decoded
	localparam func_id_t FUNC_ENCRYPT    = 10'd0;
	localparam func_id_t FUNC_READ_UPPER = 10'd1;

	////////////////////
	// Cipher constants

	typedef struct packed
	{
		word_t k3;
		word_t k2;
		word_t k1;
		word_t k0;
	} tea_key_t;

	localparam tea_key_t TEA_KEY = '{
		k0: 32'h01234567,
		k1: 32'h89abcdef,
		k2: 32'h13579248,
		k3: 32'h248a0135
	};

	localparam word_t TEA_DELTA = 32'h9e3779b9;

endpackage

`default_nettype wire

/* hdl/tea_core.sv */
// Iterative TEA encryption engine, one full round per clock, started by a one-cycle pulse
`timescale 1ns/1ps
`default_nettype none

module tea_core
	import tea_pkg::*;
#(
	parameter int ROUNDS = 32
)
(
	input  logic   clk,
	input  logic   reset,
	input  logic   start,
	input  block_t plain,
	output logic   done,
	output block_t cipher
);

	////////////////////
	// Declarations

	localparam int CW = (ROUNDS > 1) ? $clog2(ROUNDS) : 1;

	typedef logic [CW-1:0] round_cnt_t;

	localparam round_cnt_t LAST_ROUND = round_cnt_t'(ROUNDS - 1);

	typedef enum logic
	{
		ST_IDLE,
		ST_RUN
	} core_state_t;

	core_state_t state;
	round_cnt_t  round_cnt;

	// Working block and running sum
	block_t blk;
	word_t  sum;

	word_t v0_next;
	word_t v1_next;

	////////////////////
	// Round function

	// Feistel half step of TEA
	function automatic word_t tea_mix
	(
		input word_t v,
		input word_t ka,
		input word_t kb,
		input word_t s
	);
		word_t hi;
		word_t mid;
		word_t lo;
		hi  = (v << 4) + ka;
		mid = v + s;
		lo  = (v >> 5) + kb;
		return hi ^ mid ^ lo;
	endfunction

	// Second half uses the freshly mixed v0
	assign v0_next = blk.v0 + tea_mix(blk.v1, TEA_KEY.k0, TEA_KEY.k1, sum);
	assign v1_next = blk.v1 + tea_mix(v0_next, TEA_KEY.k2, TEA_KEY.k3, sum);

	////////////////////
	// Datapath

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			blk <= plain;
			sum <= TEA_DELTA;
		end
		else if (state == ST_RUN)
		begin
			blk.v0 <= v0_next;
			blk.v1 <= v1_next;
			sum    <= sum + TEA_DELTA;
		end
	end

	assign cipher = blk;

	////////////////////
	// Round sequencing

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state     <= ST_IDLE;
			round_cnt <= '0;
			done      <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						state     <= ST_RUN;
						round_cnt <= '0;
					end
				end
				ST_RUN:
				begin
					round_cnt <= round_cnt + 1'b1;
					// Last round lands together with done
					if (round_cnt == LAST_ROUND)
					begin
						state <= ST_IDLE;
						done  <= 1'b1;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	////////////////////
	// Checks

	// The controller must wait for done before the next block
	assert property (@(posedge clk) disable iff (reset)
		start |-> state == ST_IDLE)
		else $error("tea_core: start received while a block is still being encrypted");

endmodule

`default_nettype wire

/* hdl/tea_cmd_ctrl.sv */
// Command decode and response handshake of the TEA custom instruction, drives the engine
`timescale 1ns/1ps
`default_nettype none

module tea_cmd_ctrl
	import tea_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     cmd_valid,
	input  tea_cmd_t cmd,
	output logic     cmd_ready,
	output logic     rsp_valid,
	output word_t    rsp_data,
	input  logic     rsp_ready,
	output logic     start,
	output block_t   plain,
	input  logic     done,
	input  block_t   cipher
);

	////////////////////
	// Declarations

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_ENCRYPT,
		ST_RESPOND
	} ctrl_state_t;

	ctrl_state_t state;

	// Upper word of the last ciphertext, served by read-upper
	word_t result;

	logic cmd_fire;
	logic is_encrypt;
	logic is_read_upper;

	////////////////////
	// Decode

	assign cmd_ready = (state == ST_IDLE);
	assign cmd_fire  = cmd_valid && cmd_ready;

	assign is_encrypt    = (cmd.function_id[1:0] == FUNC_ENCRYPT[1:0]);
	assign is_read_upper = (cmd.function_id[1:0] == FUNC_READ_UPPER[1:0]);

	////////////////////
	// Control FSM

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state     <= ST_IDLE;
			start     <= 1'b0;
			rsp_valid <= 1'b0;
			result    <= '0;
		end
		else
		begin
			start <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					// Other function codes are taken and dropped
					if (cmd_fire && is_encrypt)
					begin
						start <= 1'b1;
						state <= ST_ENCRYPT;
					end
					else if (cmd_fire && is_read_upper)
					begin
						state <= ST_RESPOND;
					end
				end
				ST_ENCRYPT:
				begin
					if (done)
					begin
						result    <= cipher.v1;
						rsp_valid <= 1'b1;
						state     <= ST_RESPOND;
					end
				end
				ST_RESPOND:
				begin
					// Read-upper arrives here with valid still low
					if (!rsp_valid)
					begin
						rsp_valid <= 1'b1;
					end
					else if (rsp_ready)
					begin
						rsp_valid <= 1'b0;
						state     <= ST_IDLE;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	////////////////////
	// Payload

	always_ff @(posedge clk)
	begin
		if (cmd_fire && is_encrypt)
		begin
			plain.v0 <= cmd.inputs_0;
			plain.v1 <= cmd.inputs_1;
		end

		if (cmd_fire && is_read_upper)
		begin
			rsp_data <= result;
		end
		else if (state == ST_ENCRYPT && done)
		begin
			rsp_data <= cipher.v0;
		end
	end

	////////////////////
	// Checks

	assert property (@(posedge clk) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
		else $error("tea_cmd_ctrl: response changed while stalled");

	// No new command while a block or a response is outstanding
	assert property (@(posedge clk) disable iff (reset)
		(cmd_fire && (is_encrypt || is_read_upper))
		|| (!cmd_ready && !(rsp_valid && rsp_ready)) |=> !cmd_ready)
		else $error("tea_cmd_ctrl: cmd_ready rose before the response transfer");

endmodule

`default_nettype wire

/* hdl/tea_accel.sv */
// Top level of the TEA custom-instruction accelerator, command controller plus engine
`timescale 1ns/1ps
`default_nettype none

module tea_accel
	import tea_pkg::*;
#(
	parameter int ROUNDS = 32
)
(
	input  logic     clk,
	input  logic     reset,
	input  logic     cmd_valid,
	input  tea_cmd_t cmd,
	output logic     cmd_ready,
	output logic     rsp_valid,
	output word_t    rsp_data,
	input  logic     rsp_ready
);

	////////////////////
	// Engine link

	logic   start;
	block_t plain;
	logic   done;
	block_t cipher;

	tea_cmd_ctrl i_tea_cmd_ctrl
	(
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_ready (rsp_ready),
		.start     (start),
		.plain     (plain),
		.done      (done),
		.cipher    (cipher)
	);

	// Fixed latency of ROUNDS cycles from start to done
	tea_core #(
		.ROUNDS (ROUNDS)
	) i_tea_core
	(
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.plain  (plain),
		.done   (done),
		.cipher (cipher)
	);

endmodule

`default_nettype wire

/* test/tb_tea_accel.sv */
// Self-checking testbench for the TEA accelerator, runs the commands listed in test/tea_vectors.txt
`timescale 1ns/1ps
`default_nettype none

module tb_tea_accel
	import tea_pkg::*;
();

	////////////////////
	// Declarations

	localparam int ROUNDS      = 32;
	localparam int CLK_PERIOD  = 20;
	localparam int DRIVE_DELAY = 1;

	// How a vector's response is judged
	typedef enum logic [1:0]
	{
		MODE_NONE,
		MODE_LITERAL,
		MODE_CIPHER_LOW,
		MODE_CIPHER_HIGH
	} check_mode_t;

	typedef struct packed
	{
		func_id_t    func;
		word_t       in0;
		word_t       in1;
		check_mode_t mode;
		word_t       expected;
	} vector_t;

	logic     clk;
	logic     reset;
	logic     cmd_valid;
	tea_cmd_t cmd;
	logic     cmd_ready;
	logic     rsp_valid;
	word_t    rsp_data;
	logic     rsp_ready;

	vector_t     vectors[$];
	string       names[$];
	bit          vectors_loaded;
	logic [31:0] lfsr;

	// Reference copy of the result register
	block_t model_result;

	int error_count;
	int tests_run;
	int tests_failed;

	tea_accel i_tea_accel
	(
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_ready (rsp_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	////////////////////
	// Helpers

	// Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic [31:0] shifted;
		shifted = state >> 1;
		if (state[0])
		begin
			shifted = shifted ^ 32'h80200003;
		end
		return shifted;
	endfunction

	// Textbook TEA encryption
	function automatic block_t tea_reference(input word_t p0, input word_t p1);
		word_t  y;
		word_t  z;
		word_t  s;
		block_t blk;
		y = p0;
		z = p1;
		s = '0;
		for (int i = 0; i < ROUNDS; i++)
		begin
			s = s + TEA_DELTA;
			y = y + (((z << 4) + TEA_KEY.k0) ^ (z + s) ^ ((z >> 5) + TEA_KEY.k1));
			z = z + (((y << 4) + TEA_KEY.k2) ^ (y + s) ^ ((y >> 5) + TEA_KEY.k3));
		end
		blk.v0 = y;
		blk.v1 = z;
		return blk;
	endfunction

	// Outputs are sampled and inputs driven just after the edge
	task automatic next_cycle();
		@(posedge clk);
		#(DRIVE_DELAY);
		lfsr      = lfsr_step(lfsr);
		rsp_ready = lfsr[0];
	endtask

	task automatic load_vectors();
		int          fd;
		int          count;
		int          mode_val;
		string       line;
		string       name;
		logic [31:0] func_val;
		logic [31:0] in0_val;
		logic [31:0] in1_val;
		logic [31:0] exp_val;
		vector_t     v;
		fd = $fopen("test/tea_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("[ERROR] the vector file test/tea_vectors.txt could not be opened");
			error_count++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line.getc(0) != "#")
				begin
					count = $sscanf(line, "%s %h %h %h %d %h", name, func_val, in0_val,
						in1_val, mode_val, exp_val);
					if (count == 6)
					begin
						v.func     = func_val[9:0];
						v.in0      = in0_val;
						v.in1      = in1_val;
						v.mode     = check_mode_t'(mode_val[1:0]);
						v.expected = exp_val;
						vectors.push_back(v);
						names.push_back(name);
					end
				end
			end
			$fclose(fd);
		end
		vectors_loaded = 1'b1;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before)
		begin
			$display("PASS %s", name);
		end
		else
		begin
			tests_failed++;
			$display("FAIL %s", name);
		end
	endtask

	task automatic check_reset_state();
		int errors_before;
		errors_before = error_count;
		if (!cmd_ready)
		begin
			$display("[ERROR] reset_state: cmd_ready is low after reset");
			error_count++;
		end
		if (rsp_valid)
		begin
			$display("[ERROR] reset_state: rsp_valid is high after reset");
			error_count++;
		end
		finish_test("reset_state", errors_before);
	endtask

	////////////////////
	// Command runner

	task automatic run_vector(input string name, input vector_t v);
		int    errors_before;
		logic  accepted;
		logic  seen;
		logic  finished;
		logic  ready_reported;
		logic  change_reported;
		word_t held;
		word_t expected;
		errors_before   = error_count;
		ready_reported  = 1'b0;
		change_reported = 1'b0;

		cmd_valid       = 1'b1;
		cmd.function_id = v.func;
		cmd.inputs_0    = v.in0;
		cmd.inputs_1    = v.in1;
		accepted        = 1'b0;
		while (!accepted)
		begin
			accepted = cmd_ready;
			next_cycle();
		end
		cmd_valid = 1'b0;

		if (v.func[1:0] == FUNC_ENCRYPT[1:0])
		begin
			model_result = tea_reference(v.in0, v.in1);
		end
		case (v.mode)
			MODE_LITERAL:     expected = v.expected;
			MODE_CIPHER_LOW:  expected = model_result.v0;
			MODE_CIPHER_HIGH: expected = model_result.v1;
			default:          expected = '0;
		endcase

		if (v.mode == MODE_NONE)
		begin
			for (int n = 0; n < ROUNDS + 4; n++)
			begin
				if (rsp_valid && !change_reported)
				begin
					$display("[ERROR] %s: a response appeared for an ignored command", name);
					error_count++;
					change_reported = 1'b1;
				end
				if (!cmd_ready && !ready_reported)
				begin
					$display("[ERROR] %s: cmd_ready dropped for an ignored command", name);
					error_count++;
					ready_reported = 1'b1;
				end
				next_cycle();
			end
		end
		else
		begin
			seen     = 1'b0;
			finished = 1'b0;
			held     = '0;
			while (!finished)
			begin
				if (cmd_ready && !ready_reported)
				begin
					$display("[ERROR] %s: cmd_ready is high while the response is open", name);
					error_count++;
					ready_reported = 1'b1;
				end
				if (rsp_valid)
				begin
					if (!seen)
					begin
						seen = 1'b1;
						held = rsp_data;
					end
					else if (rsp_data !== held && !change_reported)
					begin
						$display("[ERROR] %s: rsp_data changed while the response was stalled",
							name);
						error_count++;
						change_reported = 1'b1;
					end
					finished = rsp_ready;
				end
				next_cycle();
			end
			if (!cmd_ready)
			begin
				$display("[ERROR] %s: cmd_ready did not return high after the response", name);
				error_count++;
			end
			if (rsp_valid)
			begin
				$display("[ERROR] %s: rsp_valid stayed high after the transfer", name);
				error_count++;
			end
			if (held !== expected)
			begin
				$display("[ERROR] %s: expected %h, actual %h", name, expected, held);
				error_count++;
			end
		end
		finish_test(name, errors_before);
	endtask

	////////////////////
	// Main sequence

	initial
	begin
		reset          = 1'b1;
		cmd_valid      = 1'b0;
		cmd            = '0;
		rsp_ready      = 1'b0;
		lfsr           = 32'h67f9;
		model_result   = '0;
		error_count    = 0;
		tests_run      = 0;
		tests_failed   = 0;
		vectors_loaded = 1'b0;

		load_vectors();
		if (vectors.size() == 0)
		begin
			$display("[ERROR] no vectors were read from the vector file");
			error_count++;
		end

		repeat (2) @(posedge clk);
		#(DRIVE_DELAY);
		reset = 1'b0;
		check_reset_state();

		foreach (vectors[i])
		begin
			run_vector(names[i], vectors[i]);
		end

		$display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
			tests_run, tests_run - tests_failed, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0)
		begin
			$display("TEST OK");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog, one slot of ROUNDS + 40 cycles per vector plus one for reset
	initial
	begin
		int limit;
		wait (vectors_loaded);
		limit = (vectors.size() + 1) * (ROUNDS + 40);
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* test/tea_vectors.txt */
# columns: name func_id inputs_0 inputs_1 mode expected (hex except mode)
# mode 0 no response, 1 equals expected, 2 lower word of TEA(inputs), 3 upper word of last TEA
read_after_reset 001 00000000 00000000 1 00000000
read_after_reset_b 001 ffffffff ffffffff 1 00000000
enc_zero 000 00000000 00000000 2 00000000
read_zero 001 00000000 00000000 3 00000000
enc_ones 000 ffffffff ffffffff 2 00000000
read_ones 001 00000000 00000000 3 00000000
enc_count 000 01234567 89abcdef 2 00000000
read_count 001 00000000 00000000 3 00000000
ignore_f3 003 deadbeef cafef00d 0 00000000
read_after_f3 001 00000000 00000000 3 00000000
enc_walk 000 00000001 80000000 2 00000000
ignore_f2 002 12345678 9abcdef0 0 00000000
ignore_f3_again 003 00000000 00000000 0 00000000
read_after_ignores 001 00000000 00000000 3 00000000
enc_alias_f4 004 a5a5a5a5 5a5a5a5a 2 00000000
read_alias_f5 005 00000000 00000000 3 00000000
enc_back_a 000 13579bdf 2468ace0 2 00000000
enc_back_b 000 0f1e2d3c 4b5a6978 2 00000000
read_back_b 001 00000000 00000000 3 00000000
ignore_f3ff 3ff 11111111 22222222 0 00000000
read_after_f3ff 001 00000000 00000000 3 00000000
enc_final 000 c0ffee00 00badd1e 2 00000000
read_final 001 00000000 00000000 3 00000000

/* src.f */
hdl/tea_pkg.sv
hdl/tea_core.sv
hdl/tea_cmd_ctrl.sv
hdl/tea_accel.sv
test/tb_tea_accel.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_tea_accel
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST OK

.PHONY: sim clean

# Build, run, and fail unless the pass message is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^$(PASS_MSG)$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
